// ==== common/exu_pkg.sv ====
package exu_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // Data path and instruction address
    localparam int unsigned XLEN = 32;
    localparam int unsigned VLEN = 32;
    // Scoreboard entry ID
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    // Issue to write-back, in cycles
    localparam int unsigned MULT_LATENCY = 2;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // ----------------------------------------
    // Operations of the fixed-latency units
    // ----------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // Branch unit, compare done in the ALU
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR,
        // CSR buffer
        CSR_RW,
        CSR_RS,
        CSR_RC,
        // Multiplier
        MUL,
        MULH,
        MULHU,
        MULHSU
    } fu_op_e;

endpackage

// ==== flist.f ====
common/exu_pkg.sv
flu/alu.sv
flu/branch_unit.sv
flu/mult.sv
flu/csr_buffer.sv
flu/flu_ctrl.sv
src/ex_stage.sv
tests/tb_ex_stage.sv

// ==== flu/alu.sv ====
module alu (
    input  exu_pkg::fu_op_e fu_op_i,
    input  exu_pkg::xlen_t  operand_a_i,
    input  exu_pkg::xlen_t  operand_b_i,
    output exu_pkg::xlen_t  result_o,
    output logic            branch_res_o
);
    import exu_pkg::*;

    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic [4:0] shamt;

    // Shared comparators, used by SLT(U) and branches
    assign eq    = (operand_a_i == operand_b_i);
    assign lt_s  = ($signed(operand_a_i) < $signed(operand_b_i));
    assign lt_u  = (operand_a_i < operand_b_i);
    // RV32 shift amount
    assign shamt = operand_b_i[4:0];

    // ----------------------------------------
    // Result
    // ----------------------------------------
    always_comb begin
        result_o = '0;
        unique case (fu_op_i)
            ADD:  result_o = operand_a_i + operand_b_i;
            SUB:  result_o = operand_a_i - operand_b_i;
            AND:  result_o = operand_a_i & operand_b_i;
            OR:   result_o = operand_a_i | operand_b_i;
            XOR:  result_o = operand_a_i ^ operand_b_i;
            SLL:  result_o = operand_a_i << shamt;
            SRL:  result_o = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign
            SRA:  result_o = xlen_t'($signed(operand_a_i) >>> shamt);
            SLT:  result_o = xlen_t'(lt_s);
            SLTU: result_o = xlen_t'(lt_u);
            default: result_o = '0;
        endcase
    end

    // ----------------------------------------
    // Branch comparison
    // ----------------------------------------
    always_comb begin
        branch_res_o = 1'b0;
        unique case (fu_op_i)
            BEQ:  branch_res_o = eq;
            BNE:  branch_res_o = ~eq;
            BLT:  branch_res_o = lt_s;
            BGE:  branch_res_o = ~lt_s;
            BLTU: branch_res_o = lt_u;
            BGEU: branch_res_o = ~lt_u;
            // Jumps are always taken
            JAL,
            JALR: branch_res_o = 1'b1;
            default: branch_res_o = 1'b0;
        endcase
    end

endmodule

// ==== flu/branch_unit.sv ====
module branch_unit (
    input  logic                     branch_valid_i,
    input  exu_pkg::fu_op_e          fu_op_i,
    input  exu_pkg::xlen_t           operand_a_i,
    input  exu_pkg::xlen_t           imm_i,
    input  logic [exu_pkg::VLEN-1:0] pc_i,
    input  logic                     is_compressed_i,
    input  logic                     branch_res_i,
    input  logic                     bp_taken_i,
    input  logic [exu_pkg::VLEN-1:0] bp_target_i,
    output logic [exu_pkg::VLEN-1:0] link_addr_o,
    output logic                     resolve_valid_o,
    output logic                     resolve_taken_o,
    output logic                     resolve_mispredict_o,
    output logic [exu_pkg::VLEN-1:0] resolve_target_o
);
    import exu_pkg::*;

    logic [VLEN-1:0] jump_base;
    logic [VLEN-1:0] target;
    logic            taken;

    // ----------------------------------------
    // Target and link address
    // ----------------------------------------
    // JALR jumps relative to rs1, all others relative to the PC
    assign jump_base = (fu_op_i == JALR) ? operand_a_i[VLEN-1:0] : pc_i;

    always_comb begin
        target = jump_base + imm_i[VLEN-1:0];
        // Bit 0 is cleared for JALR only
        if (fu_op_i == JALR) begin
            target[0] = 1'b0;
        end
    end

    // Next sequential PC, 16 or 32 bit instruction
    assign link_addr_o = pc_i + (is_compressed_i ? VLEN'(2) : VLEN'(4));

    // ----------------------------------------
    // Resolution against the prediction
    // ----------------------------------------
    assign taken = branch_valid_i & branch_res_i;

    assign resolve_valid_o  = branch_valid_i;
    assign resolve_taken_o  = taken;
    // Fall-through when not taken
    assign resolve_target_o = taken ? target : link_addr_o;

    // Direction wrong, or taken to the wrong place
    always_comb begin
        resolve_mispredict_o = 1'b0;
        if (branch_valid_i) begin
            if (taken != bp_taken_i) begin
                resolve_mispredict_o = 1'b1;
            end else if (taken && (bp_target_i != target)) begin
                resolve_mispredict_o = 1'b1;
            end
        end
    end

endmodule

// ==== flu/csr_buffer.sv ====
module csr_buffer (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              csr_valid_i,
    input  exu_pkg::fu_op_e                   fu_op_i,
    input  exu_pkg::xlen_t                    operand_a_i,
    input  exu_pkg::xlen_t                    imm_i,
    input  logic                              csr_commit_i,
    output logic                              csr_ready_o,
    output exu_pkg::xlen_t                    csr_result_o,
    output logic [exu_pkg::CSR_ADDR_BITS-1:0] csr_addr_o,
    output exu_pkg::fu_op_e                   csr_op_o,
    output logic                              csr_pending_o
);
    import exu_pkg::*;

    // Full entry blocks issue until it commits
    assign csr_ready_o  = ~csr_pending_o | csr_commit_i;
    // rs1 value goes straight to write-back
    assign csr_result_o = operand_a_i;

    // ----------------------------------------
    // Entry valid
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            csr_pending_o <= 1'b0;
        end else if (flush_i) begin
            csr_pending_o <= 1'b0;
        end else if (csr_valid_i) begin
            // New entry, may replace one committing this cycle
            csr_pending_o <= 1'b1;
        end else if (csr_commit_i) begin
            csr_pending_o <= 1'b0;
        end
    end

    // Address and opcode of the entry
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            csr_addr_o <= imm_i[CSR_ADDR_BITS-1:0];
            csr_op_o   <= fu_op_i;
        end
    end

    // Commit stage only retires a CSR that was buffered
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_commit_i |-> csr_pending_o)
        else $error("CSR commit without a pending entry");

endmodule

// ==== flu/flu_ctrl.sv ====
module flu_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Issue valids
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_issue_i,
    input  exu_pkg::xlen_t           operand_a_i,
    input  exu_pkg::xlen_t           operand_b_i,
    input  exu_pkg::trans_id_t       trans_id_i,
    // Unit results
    input  exu_pkg::xlen_t           alu_result_i,
    input  logic [exu_pkg::VLEN-1:0] link_addr_i,
    input  exu_pkg::xlen_t           csr_result_i,
    input  logic                     csr_ready_i,
    input  exu_pkg::xlen_t           mult_result_i,
    input  exu_pkg::trans_id_t       mult_trans_id_i,
    input  logic                     mult_valid_i,
    // Gated operands
    output exu_pkg::xlen_t           alu_operand_a_o,
    output exu_pkg::xlen_t           alu_operand_b_o,
    output exu_pkg::xlen_t           mult_operand_a_o,
    output exu_pkg::xlen_t           mult_operand_b_o,
    // Write-back port
    output exu_pkg::xlen_t           flu_result_o,
    output exu_pkg::trans_id_t       flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o
);
    import exu_pkg::*;

    // ----------------------------------------
    // Operand gating
    // ----------------------------------------
    // ALU also does the branch compare
    assign alu_operand_a_o  = (alu_valid_i | branch_valid_i) ? operand_a_i : '0;
    assign alu_operand_b_o  = (alu_valid_i | branch_valid_i) ? operand_b_i : '0;
    assign mult_operand_a_o = mult_issue_i ? operand_a_i : '0;
    assign mult_operand_b_o = mult_issue_i ? operand_b_i : '0;

    // ----------------------------------------
    // Write-back mux
    // ----------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    always_comb begin
        // Link address unless something else wins
        flu_result_o   = xlen_t'(link_addr_i);
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i) begin
            // Only case with a stored ID
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    // No issue in a multiplier write-back cycle or with a full CSR entry
    assign flu_ready_o = csr_ready_i & ~mult_valid_i;

    // Single issue port
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_issue_i}))
        else $error("more than one unit issued");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alu_valid_i | branch_valid_i | csr_valid_i | mult_issue_i) |-> flu_ready_o)
        else $error("issue while the fixed-latency units are not ready");

endmodule

// ==== flu/mult.sv ====
module mult (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               mult_valid_i,
    input  exu_pkg::fu_op_e    fu_op_i,
    input  exu_pkg::xlen_t     operand_a_i,
    input  exu_pkg::xlen_t     operand_b_i,
    input  exu_pkg::trans_id_t trans_id_i,
    output exu_pkg::xlen_t     result_o,
    output logic               mult_valid_o,
    output exu_pkg::trans_id_t mult_trans_id_o
);
    import exu_pkg::*;

    logic                   sign_a;
    logic                   sign_b;
    // Stage one
    logic                   s1_valid_q;
    logic signed [XLEN:0]   op_a_q;
    logic signed [XLEN:0]   op_b_q;
    fu_op_e                 s1_op_q;
    trans_id_t              s1_id_q;
    // Product, low 64 bits of the signed 33x33 multiply
    logic signed [2*XLEN-1:0] prod;

    // Signedness per operand, low half does not care
    assign sign_a = (fu_op_i == MUL) || (fu_op_i == MULH) || (fu_op_i == MULHSU);
    assign sign_b = (fu_op_i == MUL) || (fu_op_i == MULH);

    // ----------------------------------------
    // Valid bits, cleared by flush
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q   <= 1'b0;
            mult_valid_o <= 1'b0;
        end else begin
            s1_valid_q   <= mult_valid_i & ~flush_i;
            mult_valid_o <= s1_valid_q & ~flush_i;
        end
    end

    // Payload of both stages
    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            op_a_q  <= {sign_a & operand_a_i[XLEN-1], operand_a_i};
            op_b_q  <= {sign_b & operand_b_i[XLEN-1], operand_b_i};
            s1_op_q <= fu_op_i;
            s1_id_q <= trans_id_i;
        end
        if (s1_valid_q) begin
            result_o        <= (s1_op_q == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
            mult_trans_id_o <= s1_id_q;
        end
    end

    assign prod = op_a_q * op_b_q;

    // Each issue reaches write-back with its own ID unless flushed on the way
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_valid_i && !flush_i) ##1 (!flush_i) [* MULT_LATENCY - 1]
        |-> ##1 (mult_valid_o && (mult_trans_id_o == $past(trans_id_i, MULT_LATENCY))))
        else $error("multiply lost between issue and write-back");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and grade the run from its log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -f flist.f -o sim_ex_stage \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_ex_stage > sim.log 2>&1
cat sim.log

grep -q "Result: PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0

// ==== src/ex_stage.sv ====
module ex_stage (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    // Issue bundle
    input  exu_pkg::fu_op_e                   fu_op_i,
    input  exu_pkg::xlen_t                    operand_a_i,
    input  exu_pkg::xlen_t                    operand_b_i,
    input  exu_pkg::xlen_t                    imm_i,
    input  exu_pkg::trans_id_t                trans_id_i,
    input  logic [exu_pkg::VLEN-1:0]          pc_i,
    input  logic                              is_compressed_i,
    input  logic                              alu_valid_i,
    input  logic                              branch_valid_i,
    input  logic                              csr_valid_i,
    input  logic                              mult_valid_i,
    // Prediction and commit
    input  logic                              bp_taken_i,
    input  logic [exu_pkg::VLEN-1:0]          bp_target_i,
    input  logic                              csr_commit_i,
    // Write-back
    output exu_pkg::xlen_t                    flu_result_o,
    output exu_pkg::trans_id_t                flu_trans_id_o,
    output logic                              flu_valid_o,
    output logic                              flu_ready_o,
    // Branch resolution
    output logic                              resolve_valid_o,
    output logic                              resolve_taken_o,
    output logic                              resolve_mispredict_o,
    output logic [exu_pkg::VLEN-1:0]          resolve_target_o,
    // Buffered CSR
    output logic [exu_pkg::CSR_ADDR_BITS-1:0] csr_addr_o,
    output exu_pkg::fu_op_e                   csr_op_o,
    output logic                              csr_pending_o
);
    import exu_pkg::*;

    xlen_t           alu_operand_a;
    xlen_t           alu_operand_b;
    xlen_t           mult_operand_a;
    xlen_t           mult_operand_b;
    xlen_t           alu_result;
    xlen_t           csr_result;
    xlen_t           mult_result;
    logic            alu_branch_res;
    logic [VLEN-1:0] link_addr;
    logic            csr_ready;
    logic            mult_wb_valid;
    trans_id_t       mult_trans_id;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    flu_ctrl flu_ctrl_i (
        .clk_i,
        .rst_ni,
        .alu_valid_i,
        .branch_valid_i,
        .csr_valid_i,
        .mult_issue_i     ( mult_valid_i   ),
        .operand_a_i,
        .operand_b_i,
        .trans_id_i,
        .alu_result_i     ( alu_result     ),
        .link_addr_i      ( link_addr      ),
        .csr_result_i     ( csr_result     ),
        .csr_ready_i      ( csr_ready      ),
        .mult_result_i    ( mult_result    ),
        .mult_trans_id_i  ( mult_trans_id  ),
        .mult_valid_i     ( mult_wb_valid  ),
        .alu_operand_a_o  ( alu_operand_a  ),
        .alu_operand_b_o  ( alu_operand_b  ),
        .mult_operand_a_o ( mult_operand_a ),
        .mult_operand_b_o ( mult_operand_b ),
        .flu_result_o,
        .flu_trans_id_o,
        .flu_valid_o,
        .flu_ready_o
    );

    // ----------------------------------------
    // Units
    // ----------------------------------------
    alu alu_i (
        .fu_op_i,
        .operand_a_i  ( alu_operand_a  ),
        .operand_b_i  ( alu_operand_b  ),
        .result_o     ( alu_result     ),
        .branch_res_o ( alu_branch_res )
    );

    // Sees the ungated bundle, compare comes from the ALU
    branch_unit branch_unit_i (
        .branch_valid_i,
        .fu_op_i,
        .operand_a_i,
        .imm_i,
        .pc_i,
        .is_compressed_i,
        .branch_res_i ( alu_branch_res ),
        .bp_taken_i,
        .bp_target_i,
        .link_addr_o  ( link_addr      ),
        .resolve_valid_o,
        .resolve_taken_o,
        .resolve_mispredict_o,
        .resolve_target_o
    );

    mult mult_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .mult_valid_i,
        .fu_op_i,
        .operand_a_i     ( mult_operand_a ),
        .operand_b_i     ( mult_operand_b ),
        .trans_id_i,
        .result_o        ( mult_result    ),
        .mult_valid_o    ( mult_wb_valid  ),
        .mult_trans_id_o ( mult_trans_id  )
    );

    csr_buffer csr_buffer_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .csr_valid_i,
        .fu_op_i,
        .operand_a_i,
        .imm_i,
        .csr_commit_i,
        .csr_ready_o  ( csr_ready  ),
        .csr_result_o ( csr_result ),
        .csr_addr_o,
        .csr_op_o,
        .csr_pending_o
    );

endmodule

// ==== tests/tb_ex_stage.sv ====
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int unsigned CLK_PERIOD   = 8;
    localparam int unsigned RESET_CYCLES = 4;
    // Cycles spent by each test, idle cycles included
    localparam int unsigned ALU_CYCLES    = 10 * 2 + 1;
    localparam int unsigned BRANCH_CYCLES = 8 * 4 + 1;
    localparam int unsigned MULT_CYCLES   = 2 * 4 + 1;
    localparam int unsigned CSR_CYCLES    = 4 + 1;
    localparam int unsigned FLUSH_CYCLES  = 4 + 3 + 1;
    localparam int unsigned TEST_CYCLES   = RESET_CYCLES + 1 + ALU_CYCLES + BRANCH_CYCLES
                                          + MULT_CYCLES + CSR_CYCLES + FLUSH_CYCLES;
    localparam int unsigned WATCHDOG_CYCLES = 2 * TEST_CYCLES + 50;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    fu_op_e                   fu_op_i;
    xlen_t                    operand_a_i;
    xlen_t                    operand_b_i;
    xlen_t                    imm_i;
    trans_id_t                trans_id_i;
    logic [VLEN-1:0]          pc_i;
    logic                     is_compressed_i;
    logic                     alu_valid_i;
    logic                     branch_valid_i;
    logic                     csr_valid_i;
    logic                     mult_valid_i;
    logic                     bp_taken_i;
    logic [VLEN-1:0]          bp_target_i;
    logic                     csr_commit_i;
    xlen_t                    flu_result_o;
    trans_id_t                flu_trans_id_o;
    logic                     flu_valid_o;
    logic                     flu_ready_o;
    logic                     resolve_valid_o;
    logic                     resolve_taken_o;
    logic                     resolve_mispredict_o;
    logic [VLEN-1:0]          resolve_target_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;
    fu_op_e                   csr_op_o;
    logic                     csr_pending_o;

    integer seed = 32'h6772e5fb;
    int     checks = 0;
    int     errors = 0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ex_stage ex_stage_i (.*);

    // ----------------------------------------
    // Reference models
    // ----------------------------------------
    function automatic xlen_t alu_model(fu_op_e op, xlen_t a, xlen_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return xlen_t'($signed(a) >>> b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // Branch condition, jumps always taken
    function automatic logic branch_cond(fu_op_e op, xlen_t a, xlen_t b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // 64-bit product of the extended operands, low or high half
    function automatic xlen_t mult_model(fu_op_e op, xlen_t a, xlen_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = (op == MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
        eb = (op == MUL || op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
        p  = ea * eb;
        return (op == MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // All valids, flush and commit low from the next edge
    task automatic drive_idle();
        @(posedge clk_i);
        alu_valid_i    <= 1'b0;
        branch_valid_i <= 1'b0;
        csr_valid_i    <= 1'b0;
        mult_valid_i   <= 1'b0;
        flush_i        <= 1'b0;
        csr_commit_i   <= 1'b0;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic alu_ops();
        xlen_t     a;
        xlen_t     b;
        trans_id_t id;
        for (int i = int'(ADD); i <= int'(SLTU); i++) begin
            for (int r = 0; r < 2; r++) begin
                a  = $random(seed);
                b  = $random(seed);
                id = trans_id_t'(i + r);
                @(posedge clk_i);
                fu_op_i     <= fu_op_e'(i);
                operand_a_i <= a;
                operand_b_i <= b;
                trans_id_i  <= id;
                alu_valid_i <= 1'b1;
                @(negedge clk_i);
                check_hex("flu_valid_o", 32'(flu_valid_o), 32'd1);
                check_hex("flu_result_o", flu_result_o, alu_model(fu_op_e'(i), a, b));
                check_hex("flu_trans_id_o", 32'(flu_trans_id_o), 32'(id));
            end
        end
        drive_idle();
    endtask

    task automatic branch_resolution();
        xlen_t     a;
        xlen_t     b;
        xlen_t     imm;
        xlen_t     pc;
        xlen_t     target;
        xlen_t     link;
        xlen_t     pred_target;
        logic      cond;
        logic      comp;
        logic      pred_taken;
        logic      exp_mispredict;
        trans_id_t id;
        for (int i = int'(BEQ); i <= int'(JALR); i++) begin
            // k picks operand equality, compressed size and prediction quality
            for (int k = 0; k < 4; k++) begin
                a      = $random(seed);
                b      = k[0] ? a : xlen_t'($random(seed));
                imm    = xlen_t'($random(seed)) & 32'hffff_fffe;
                pc     = xlen_t'($random(seed)) & 32'hffff_fffe;
                comp   = (k == 1) || (k == 2);
                id     = trans_id_t'(i + k);
                cond   = branch_cond(fu_op_e'(i), a, b);
                target = (fu_op_e'(i) == JALR) ? ((a + imm) & 32'hffff_fffe) : pc + imm;
                link   = pc + (comp ? 32'd2 : 32'd4);
                pred_taken     = k[1] ? cond : ~cond;
                pred_target    = (k == 3) ? target + 32'd4 : target;
                exp_mispredict = (pred_taken != cond) || (cond && (pred_target != target));
                @(posedge clk_i);
                fu_op_i         <= fu_op_e'(i);
                operand_a_i     <= a;
                operand_b_i     <= b;
                imm_i           <= imm;
                pc_i            <= pc;
                is_compressed_i <= comp;
                trans_id_i      <= id;
                bp_taken_i      <= pred_taken;
                bp_target_i     <= pred_target;
                branch_valid_i  <= 1'b1;
                @(negedge clk_i);
                check_hex("resolve_valid_o", 32'(resolve_valid_o), 32'd1);
                check_hex("resolve_taken_o", 32'(resolve_taken_o), 32'(cond));
                check_hex("resolve_target_o", resolve_target_o, cond ? target : link);
                check_hex("resolve_mispredict_o", 32'(resolve_mispredict_o),
                          32'(exp_mispredict));
                check_hex("flu_result_o", flu_result_o, link);
                check_hex("flu_trans_id_o", 32'(flu_trans_id_o), 32'(id));
            end
        end
        drive_idle();
    endtask

    // Two pairs of back-to-back issues, each followed by two write-back cycles
    task automatic mult_pipeline();
        fu_op_e mult_ops [4] = '{MUL, MULH, MULHU, MULHSU};
        xlen_t  a [4];
        xlen_t  b [4];
        int     idx;
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 2; s++) begin
                idx    = 2 * p + s;
                a[idx] = $random(seed);
                b[idx] = $random(seed);
                @(posedge clk_i);
                fu_op_i      <= mult_ops[idx];
                operand_a_i  <= a[idx];
                operand_b_i  <= b[idx];
                trans_id_i   <= trans_id_t'(idx + 1);
                mult_valid_i <= 1'b1;
                @(negedge clk_i);
                check_hex("flu_ready_o", 32'(flu_ready_o), 32'd1);
                check_hex("flu_valid_o", 32'(flu_valid_o), 32'd0);
            end
            for (int s = 0; s < 2; s++) begin
                idx = 2 * p + s;
                drive_idle();
                @(negedge clk_i);
                check_hex("flu_valid_o", 32'(flu_valid_o), 32'd1);
                check_hex("flu_ready_o", 32'(flu_ready_o), 32'd0);
                check_hex("flu_trans_id_o", 32'(flu_trans_id_o), 32'(idx + 1));
                check_hex("flu_result_o", flu_result_o,
                          mult_model(mult_ops[idx], a[idx], b[idx]));
            end
        end
        drive_idle();
    endtask

    task automatic csr_entry();
        xlen_t a;
        xlen_t imm;
        a   = $random(seed);
        imm = $random(seed);
        @(posedge clk_i);
        fu_op_i     <= CSR_RS;
        operand_a_i <= a;
        imm_i       <= imm;
        trans_id_i  <= trans_id_t'(5);
        csr_valid_i <= 1'b1;
        @(negedge clk_i);
        check_hex("flu_valid_o", 32'(flu_valid_o), 32'd1);
        check_hex("flu_result_o", flu_result_o, a);
        check_hex("flu_trans_id_o", 32'(flu_trans_id_o), 32'd5);
        // Entry held from the next cycle
        drive_idle();
        @(negedge clk_i);
        check_hex("csr_pending_o", 32'(csr_pending_o), 32'd1);
        check_hex("csr_addr_o", 32'(csr_addr_o), 32'(imm[11:0]));
        check_hex("csr_op_o", 32'(csr_op_o), 32'(CSR_RS));
        check_hex("flu_ready_o", 32'(flu_ready_o), 32'd0);
        @(posedge clk_i);
        csr_commit_i <= 1'b1;
        @(negedge clk_i);
        check_hex("flu_ready_o", 32'(flu_ready_o), 32'd1);
        drive_idle();
        @(negedge clk_i);
        check_hex("csr_pending_o", 32'(csr_pending_o), 32'd0);
        check_hex("flu_ready_o", 32'(flu_ready_o), 32'd1);
    endtask

    task automatic flush_behavior();
        // Multiply flushed while in stage one
        @(posedge clk_i);
        fu_op_i      <= MUL;
        operand_a_i  <= $random(seed);
        operand_b_i  <= $random(seed);
        trans_id_i   <= trans_id_t'(3);
        mult_valid_i <= 1'b1;
        @(posedge clk_i);
        mult_valid_i <= 1'b0;
        flush_i      <= 1'b1;
        for (int c = 0; c < 2; c++) begin
            drive_idle();
            @(negedge clk_i);
            check_hex("flu_valid_o", 32'(flu_valid_o), 32'd0);
            check_hex("flu_ready_o", 32'(flu_ready_o), 32'd1);
        end
        // Pending CSR dropped by flush
        @(posedge clk_i);
        fu_op_i     <= CSR_RW;
        imm_i       <= $random(seed);
        csr_valid_i <= 1'b1;
        @(posedge clk_i);
        csr_valid_i <= 1'b0;
        flush_i     <= 1'b1;
        @(negedge clk_i);
        check_hex("csr_pending_o", 32'(csr_pending_o), 32'd1);
        drive_idle();
        @(negedge clk_i);
        check_hex("csr_pending_o", 32'(csr_pending_o), 32'd0);
        check_hex("flu_ready_o", 32'(flu_ready_o), 32'd1);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        fu_op_i         = ADD;
        operand_a_i     = '0;
        operand_b_i     = '0;
        imm_i           = '0;
        trans_id_i      = '0;
        pc_i            = '0;
        is_compressed_i = 1'b0;
        alu_valid_i     = 1'b0;
        branch_valid_i  = 1'b0;
        csr_valid_i     = 1'b0;
        mult_valid_i    = 1'b0;
        bp_taken_i      = 1'b0;
        bp_target_i     = '0;
        csr_commit_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_hex("flu_valid_o", 32'(flu_valid_o), 32'd0);
        check_hex("resolve_valid_o", 32'(resolve_valid_o), 32'd0);
        check_hex("csr_pending_o", 32'(csr_pending_o), 32'd0);
        check_hex("flu_ready_o", 32'(flu_ready_o), 32'd1);
        alu_ops();
        branch_resolution();
        mult_pipeline();
        csr_entry();
        flush_behavior();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule
